// ==== hw/cicPkg.sv ====
package cicPkg;

    // **********************************************************************
    // datapath widths
    // **********************************************************************

    // raw sample width from the converter
    localparam int inputWidth = 18;

    // integrator, comb and output width
    localparam int accWidth = 48;

    // right shift applied to the aligned input
    localparam int shiftWidth = 5;

    // **********************************************************************
    // sample and configuration bundles
    // **********************************************************************

    // one input pair as it arrives
    typedef struct packed {
        logic signed [inputWidth-1:0] i;
        logic signed [inputWidth-1:0] q;
    } iqSample_t;

    // full width pair, used from the aligner through to the output
    typedef struct packed {
        logic signed [accWidth-1:0] i;
        logic signed [accWidth-1:0] q;
    } iqWide_t;

    // static settings from the register block to the datapath
    typedef struct packed {
        logic                  enable;
        logic [shiftWidth-1:0] shift;
    } cicConfig_t;

    // **********************************************************************
    // register map, byte offsets of 32-bit words
    // **********************************************************************

    typedef enum logic [11:0] {
        REG_CTRL       = 12'h000,
        REG_DECIMATION = 12'h004,
        REG_SHIFT      = 12'h008,
        REG_OUTCOUNT   = 12'h00C
    } cicReg_e;

endpackage

// ==== hw/inputAligner.sv ====
`timescale 1ns/1ps

module inputAligner import cicPkg::*; (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  sampleValid,
    input  iqSample_t             inSample,
    input  logic [shiftWidth-1:0] shift,
    output iqWide_t               aligned,
    output logic                  alignedValid
);

    // put the sample at the top of the word, then scale down by the shift
    function automatic logic signed [accWidth-1:0] alignChannel(
        input logic signed [inputWidth-1:0] value,
        input logic [shiftWidth-1:0]        amount
    );
        logic signed [accWidth-1:0] placed;
        placed = {value, {(accWidth-inputWidth){1'b0}}};
        return placed >>> amount;
    endfunction

    always_ff @(posedge clk) begin
        if (reset) begin
            alignedValid <= 1'b0;
        end else begin
            alignedValid <= sampleValid;
        end
    end

    // payload only moves on a valid sample
    always_ff @(posedge clk) begin
        if (sampleValid) begin
            aligned.i <= alignChannel(inSample.i, shift);
            aligned.q <= alignChannel(inSample.q, shift);
        end
    end

endmodule

// ==== hw/cicIntegrator.sv ====
`timescale 1ns/1ps

module cicIntegrator import cicPkg::*; (
    input  logic    clk,
    input  logic    reset,
    input  logic    enable,
    input  logic    alignedValid,
    input  iqWide_t aligned,
    output iqWide_t integrated
);

    iqWide_t stage0;
    iqWide_t stage1;
    iqWide_t stage2;

    // per-channel add, wraps modulo 2^48
    function automatic iqWide_t addPair(
        input iqWide_t a,
        input iqWide_t b
    );
        iqWide_t sum;
        sum.i = a.i + b.i;
        sum.q = a.q + b.q;
        return sum;
    endfunction

    // **********************************************************************
    // three integrators, each fed by the previous stage's old value
    // **********************************************************************

    always_ff @(posedge clk) begin
        if (reset || !enable) begin
            stage0 <= '0;
            stage1 <= '0;
            stage2 <= '0;
        end else if (alignedValid) begin
            stage0 <= addPair(stage0, aligned);
            stage1 <= addPair(stage1, stage0);
            stage2 <= addPair(stage2, stage1);
        end
    end

    assign integrated = stage2;

endmodule

// ==== hw/cicComb.sv ====
`timescale 1ns/1ps

module cicComb import cicPkg::*; (
    input  logic    clk,
    input  logic    reset,
    input  logic    dump,
    input  iqWide_t integrated,
    output iqWide_t outSample,
    output logic    outValid
);

    // one guard bit for the x3 terms
    localparam int tapWidth = accWidth + 1;

    logic signed [accWidth-1:0] combIn [2];
    logic signed [tapWidth-1:0] xExt [2];
    logic signed [tapWidth-1:0] x3 [2];
    logic signed [tapWidth-1:0] sum3 [2];

    logic signed [tapWidth-1:0] tap0 [2];
    logic signed [tapWidth-1:0] tap1 [2];
    logic signed [tapWidth-1:0] tap2 [2];
    logic signed [accWidth-1:0] tap3 [2];

    // channel 0 is I, channel 1 is Q
    assign combIn[0] = integrated.i;
    assign combIn[1] = integrated.q;

    // **********************************************************************
    // (1 - z^-1)^3 = 1 - 3z^-1 + 3z^-2 - z^-3 in transposed form
    // **********************************************************************

    always_comb begin
        for (int ch = 0; ch < 2; ch++) begin
            xExt[ch] = {combIn[ch][accWidth-1], combIn[ch]};
            x3[ch]   = xExt[ch] + {combIn[ch], 1'b0};
            sum3[ch] = tap2[ch] + xExt[ch];
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            outValid <= 1'b0;
            for (int ch = 0; ch < 2; ch++) begin
                tap0[ch] <= '0;
                tap1[ch] <= '0;
                tap2[ch] <= '0;
                tap3[ch] <= '0;
            end
        end else begin
            outValid <= dump;
            if (dump) begin
                for (int ch = 0; ch < 2; ch++) begin
                    tap0[ch] <= xExt[ch];
                    tap1[ch] <= x3[ch] - tap0[ch];
                    tap2[ch] <= tap1[ch] - x3[ch];
                    // no rounding, just drop the guard bit
                    tap3[ch] <= sum3[ch][accWidth-1:0];
                end
            end
        end
    end

    assign outSample.i = tap3[0];
    assign outSample.q = tap3[1];

endmodule

// ==== hw/cicDecimator.sv ====
`timescale 1ns/1ps

module cicDecimator import cicPkg::*; #(
    parameter int decimationWidth = 10
) (
    input  logic                       clk,
    input  logic                       reset,
    input  cicConfig_t                 cfg,
    input  logic [decimationWidth-1:0] decimation,
    input  logic                       sampleValid,
    input  iqSample_t                  inSample,
    output iqWide_t                    outSample,
    output logic                       outValid
);

    iqWide_t                    aligned;
    logic                       alignedValid;
    iqWide_t                    integrated;

    logic [decimationWidth-1:0] decCount;
    logic                       dump;

    // **********************************************************************
    // decimation counter
    // **********************************************************************

    // held at its reset value while the filter is disabled
    always_ff @(posedge clk) begin
        if (reset || !cfg.enable) begin
            decCount <= decimationWidth'(1);
            dump     <= 1'b0;
        end else if (sampleValid) begin
            if (decCount == '0) begin
                decCount <= decimation;
                dump     <= 1'b1;
            end else begin
                decCount <= decCount - 1'b1;
                dump     <= 1'b0;
            end
        end else begin
            dump <= 1'b0;
        end
    end

    // **********************************************************************
    // datapath stages
    // **********************************************************************

    inputAligner aligner_i (
        .clk          (clk),
        .reset        (reset),
        .sampleValid  (sampleValid),
        .inSample     (inSample),
        .shift        (cfg.shift),
        .aligned      (aligned),
        .alignedValid (alignedValid)
    );

    cicIntegrator integrator_i (
        .clk          (clk),
        .reset        (reset),
        .enable       (cfg.enable),
        .alignedValid (alignedValid),
        .aligned      (aligned),
        .integrated   (integrated)
    );

    cicComb comb_i (
        .clk        (clk),
        .reset      (reset),
        .dump       (dump),
        .integrated (integrated),
        .outSample  (outSample),
        .outValid   (outValid)
    );

endmodule

// ==== hw/cicRegs.sv ====
`timescale 1ns/1ps

module cicRegs import cicPkg::*; #(
    parameter int decimationWidth = 10
) (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       pSel,
    input  logic                       pEnable,
    input  logic                       pWrite,
    input  logic [11:0]                pAddr,
    input  logic [31:0]                pWData,
    output logic [31:0]                pRData,
    output logic                       pSlvErr,
    input  logic                       outValid,
    output cicConfig_t                 cfg,
    output logic [decimationWidth-1:0] decimation
);

    localparam int countWidth = 16;

    logic                       enableReg;
    logic [decimationWidth-1:0] decimationReg;
    logic [shiftWidth-1:0]      shiftReg;
    logic [countWidth-1:0]      outCount;

    logic                       setupPhase;
    logic                       writeAccess;
    logic                       mapped;
    logic [31:0]                readData;

    assign setupPhase  = pSel && !pEnable;
    assign writeAccess = pSel && pEnable && pWrite;

    // **********************************************************************
    // address decode and read mux
    // **********************************************************************

    always_comb begin
        mapped   = 1'b1;
        readData = '0;
        case (pAddr)
            REG_CTRL:       readData[0] = enableReg;
            REG_DECIMATION: readData[decimationWidth-1:0] = decimationReg;
            REG_SHIFT:      readData[shiftWidth-1:0] = shiftReg;
            REG_OUTCOUNT:   readData[countWidth-1:0] = outCount;
            default:        mapped = 1'b0;
        endcase
    end

    // read data and error are captured at the setup edge for the access cycle
    always_ff @(posedge clk) begin
        if (reset) begin
            pRData  <= '0;
            pSlvErr <= 1'b0;
        end else begin
            pSlvErr <= setupPhase && !mapped;
            if (setupPhase) begin
                pRData <= readData;
            end
        end
    end

    // **********************************************************************
    // writable registers
    // **********************************************************************

    always_ff @(posedge clk) begin
        if (reset) begin
            enableReg     <= 1'b0;
            decimationReg <= decimationWidth'(3);
            shiftReg      <= '0;
        end else if (writeAccess) begin
            case (pAddr)
                REG_CTRL:       enableReg <= pWData[0];
                REG_DECIMATION: decimationReg <= pWData[decimationWidth-1:0];
                REG_SHIFT:      shiftReg <= pWData[shiftWidth-1:0];
                default:        ;
            endcase
        end
    end

    // output pair counter, a write of any value clears it
    always_ff @(posedge clk) begin
        if (reset) begin
            outCount <= '0;
        end else if (writeAccess && pAddr == REG_OUTCOUNT) begin
            outCount <= '0;
        end else if (outValid) begin
            outCount <= outCount + 1'b1;
        end
    end

    assign cfg        = '{enable: enableReg, shift: shiftReg};
    assign decimation = decimationReg;

endmodule

// ==== hw/cicDecimatorTop.sv ====
`timescale 1ns/1ps

module cicDecimatorTop import cicPkg::*; #(
    parameter int decimationWidth = 10
) (
    input  logic        clk,
    input  logic        reset,

    // APB slave
    input  logic        pSel,
    input  logic        pEnable,
    input  logic        pWrite,
    input  logic [11:0] pAddr,
    input  logic [31:0] pWData,
    output logic [31:0] pRData,
    output logic        pSlvErr,

    // sample stream in and out
    input  logic        sampleValid,
    input  iqSample_t   inSample,
    output iqWide_t     outSample,
    output logic        outValid
);

    cicConfig_t                 cfg;
    logic [decimationWidth-1:0] decimation;

    cicRegs #(
        .decimationWidth (decimationWidth)
    ) regs_i (
        .clk        (clk),
        .reset      (reset),
        .pSel       (pSel),
        .pEnable    (pEnable),
        .pWrite     (pWrite),
        .pAddr      (pAddr),
        .pWData     (pWData),
        .pRData     (pRData),
        .pSlvErr    (pSlvErr),
        .outValid   (outValid),
        .cfg        (cfg),
        .decimation (decimation)
    );

    cicDecimator #(
        .decimationWidth (decimationWidth)
    ) decimator_i (
        .clk         (clk),
        .reset       (reset),
        .cfg         (cfg),
        .decimation  (decimation),
        .sampleValid (sampleValid),
        .inSample    (inSample),
        .outSample   (outSample),
        .outValid    (outValid)
    );

endmodule

// ==== tests/cicDecimatorTb.sv ====
`timescale 1ns/1ps

module cicDecimatorTb import cicPkg::*; ();

    localparam int          decimationWidth = 10;
    localparam int          timeoutCycles   = 20000;
    localparam logic [11:0] unmappedAddr    = 12'h010;
    localparam logic [31:0] decimationMask  = (32'd1 << decimationWidth) - 1;
    localparam logic [31:0] shiftMask       = (32'd1 << shiftWidth) - 1;

    logic        clk;
    logic        reset;
    logic        pSel;
    logic        pEnable;
    logic        pWrite;
    logic [11:0] pAddr;
    logic [31:0] pWData;
    logic [31:0] pRData;
    logic        pSlvErr;
    logic        sampleValid;
    iqSample_t   inSample;
    iqWide_t     outSample;
    logic        outValid;

    int          cycleCount = 0;
    int          testErrors;
    int          testsPassed;
    int          testsFailed;
    int          pulseCount;
    iqWide_t     captured [$];
    logic [15:0] lfsrState;

    cicDecimatorTop #(
        .decimationWidth (decimationWidth)
    ) cicDecimatorTop_i (
        .clk         (clk),
        .reset       (reset),
        .pSel        (pSel),
        .pEnable     (pEnable),
        .pWrite      (pWrite),
        .pAddr       (pAddr),
        .pWData      (pWData),
        .pRData      (pRData),
        .pSlvErr     (pSlvErr),
        .sampleValid (sampleValid),
        .inSample    (inSample),
        .outSample   (outSample),
        .outValid    (outValid)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        cycleCount++;
        if (cycleCount >= timeoutCycles) begin
            $display("error: run stopped after %0d cycles without finishing", cycleCount);
            $display("*** FAILED ***");
            $finish;
        end
    end

    // **********************************************************************
    // clocking, capture and random helpers
    // **********************************************************************

    // every wait ends on a falling edge where registered outputs are stable
    task automatic tick();
        @(negedge clk);
        if (outValid === 1'b1) begin
            pulseCount++;
            captured.push_back(outSample);
        end
    endtask

    task automatic idle(input int count);
        repeat (count) tick();
    endtask

    task automatic clearCapture();
        pulseCount = 0;
        captured.delete();
    endtask

    // 16-bit Galois LFSR with taps x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic nextBit();
        logic outBit;
        outBit    = lfsrState[0];
        lfsrState = lfsrState >> 1;
        if (outBit) begin
            lfsrState = lfsrState ^ 16'hB400;
        end
        return outBit;
    endfunction

    function automatic logic [31:0] randomBits(input int count);
        logic [31:0] bits;
        bits = '0;
        for (int k = 0; k < count; k++) begin
            bits = {bits[30:0], nextBit()};
        end
        return bits;
    endfunction

    // **********************************************************************
    // APB transfers
    // **********************************************************************

    task automatic apbWrite(input logic [11:0] addr, input logic [31:0] data,
                            output logic err);
        pSel    = 1'b1;
        pEnable = 1'b0;
        pWrite  = 1'b1;
        pAddr   = addr;
        pWData  = data;
        tick();
        pEnable = 1'b1;
        err     = pSlvErr;
        tick();
        pSel    = 1'b0;
        pEnable = 1'b0;
        pWrite  = 1'b0;
    endtask

    task automatic apbRead(input logic [11:0] addr, output logic [31:0] data,
                           output logic err);
        pSel    = 1'b1;
        pEnable = 1'b0;
        pWrite  = 1'b0;
        pAddr   = addr;
        tick();
        pEnable = 1'b1;
        data    = pRData;
        err     = pSlvErr;
        tick();
        pSel    = 1'b0;
        pEnable = 1'b0;
    endtask

    task automatic compareWord(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        if (got !== expected) begin
            $display("[FAIL] %s: got 0x%08h, expected 0x%08h", name, got, expected);
            testErrors++;
        end
    endtask

    task automatic compareWide(input string name, input iqWide_t got, input iqWide_t expected);
        if (got.i !== expected.i) begin
            $display("[FAIL] %s.i: got 0x%012h, expected 0x%012h", name, got.i, expected.i);
            testErrors++;
        end
        if (got.q !== expected.q) begin
            $display("[FAIL] %s.q: got 0x%012h, expected 0x%012h", name, got.q, expected.q);
            testErrors++;
        end
    endtask

    task automatic setReg(input logic [11:0] addr, input logic [31:0] data);
        logic err;
        apbWrite(addr, data, err);
        if (err !== 1'b0) begin
            $display("error: write to offset 0x%03h was refused with pSlvErr", addr);
            testErrors++;
        end
    endtask

    task automatic readCheck(input logic [11:0] addr, input logic [31:0] expected,
                             input string name);
        logic [31:0] data;
        logic        err;
        apbRead(addr, data, err);
        compareWord(name, data, expected);
        compareWord({name, " pSlvErr"}, 32'(err), 32'd0);
    endtask

    task automatic finishTest(input string name);
        if (testErrors == 0) begin
            testsPassed++;
            $display("test %s: ok", name);
        end else begin
            testsFailed++;
            $display("test %s: failed with %0d errors", name, testErrors);
        end
    endtask

    // **********************************************************************
    // sample stream and DC model
    // **********************************************************************

    // one sample every other cycle
    task automatic feedSamples(input iqSample_t value, input int count);
        for (int k = 0; k < count; k++) begin
            inSample    = value;
            sampleValid = 1'b1;
            tick();
            sampleValid = 1'b0;
            tick();
        end
    endtask

    // settled output is input * 2^(30 - shift) * R^3 wrapped to 48 bits
    function automatic iqWide_t expectedDc(input iqSample_t value, input int shift,
                                           input int rate);
        longint  scale;
        longint  prodI;
        longint  prodQ;
        iqWide_t result;
        scale    = (longint'(1) << (30 - shift)) * rate * rate * rate;
        prodI    = longint'(value.i) * scale;
        prodQ    = longint'(value.q) * scale;
        result.i = prodI[accWidth-1:0];
        result.q = prodQ[accWidth-1:0];
        return result;
    endfunction

    // the first four outputs still hold start-up taps
    task automatic checkSettled(input string name, input iqWide_t expected);
        if (captured.size() < 6) begin
            $display("error: %s produced only %0d output pairs", name, captured.size());
            testErrors++;
        end else begin
            for (int k = 4; k < captured.size(); k++) begin
                compareWide($sformatf("%s outSample[%0d]", name, k), captured[k], expected);
            end
        end
    endtask

    task automatic runDc(input iqSample_t value, input int shift, input int rate,
                         input int count, input string name);
        setReg(REG_CTRL, 32'd0);
        setReg(REG_DECIMATION, 32'(rate - 1));
        setReg(REG_SHIFT, 32'(shift));
        inSample = value;
        setReg(REG_CTRL, 32'd1);
        clearCapture();
        feedSamples(value, count);
        idle(4);
        checkSettled(name, expectedDc(value, shift, rate));
    endtask

    // **********************************************************************
    // directed tests
    // **********************************************************************

    task automatic checkRegisters();
        logic [31:0] data;
        logic        err;
        testErrors = 0;
        readCheck(REG_CTRL, 32'd0, "CTRL");
        readCheck(REG_DECIMATION, 32'd3, "DECIMATION");
        readCheck(REG_SHIFT, 32'd0, "SHIFT");
        readCheck(REG_OUTCOUNT, 32'd0, "OUTCOUNT");
        setReg(REG_CTRL, 32'hFFFF_FFFF);
        readCheck(REG_CTRL, 32'd1, "CTRL");
        setReg(REG_CTRL, 32'h0000_0002);
        readCheck(REG_CTRL, 32'd0, "CTRL");
        setReg(REG_DECIMATION, 32'h0001_2345);
        readCheck(REG_DECIMATION, 32'h0001_2345 & decimationMask, "DECIMATION");
        setReg(REG_SHIFT, 32'hFFFF_FFF3);
        readCheck(REG_SHIFT, 32'hFFFF_FFF3 & shiftMask, "SHIFT");
        apbWrite(unmappedAddr, 32'hFFFF_FFFF, err);
        compareWord("pSlvErr on unmapped write", 32'(err), 32'd1);
        apbRead(unmappedAddr, data, err);
        compareWord("pRData on unmapped read", data, 32'd0);
        compareWord("pSlvErr on unmapped read", 32'(err), 32'd1);
        readCheck(REG_CTRL, 32'd0, "CTRL");
        readCheck(REG_SHIFT, 32'hFFFF_FFF3 & shiftMask, "SHIFT");
        finishTest("registers");
    endtask

    task automatic checkDcGain();
        iqSample_t value;
        testErrors = 0;
        value.i = 18'sd12345;
        value.q = -18'sd54321;
        runDc(value, 6, 4, 40, "dc gain");
        finishTest("dc gain");
    endtask

    task automatic checkOutputRate();
        iqSample_t value;
        int        expectedPairs;
        testErrors    = 0;
        value.i       = 18'sd1000;
        value.q       = 18'sd2000;
        expectedPairs = 64 / 8;
        setReg(REG_CTRL, 32'd0);
        setReg(REG_OUTCOUNT, 32'd0);
        setReg(REG_DECIMATION, 32'd7);
        setReg(REG_SHIFT, 32'd10);
        setReg(REG_CTRL, 32'd1);
        clearCapture();
        feedSamples(value, 64);
        idle(4);
        if (pulseCount < expectedPairs - 1 || pulseCount > expectedPairs + 1) begin
            $display("error: %0d output pairs for 64 samples, expected %0d within one",
                     pulseCount, expectedPairs);
            testErrors++;
        end
        readCheck(REG_OUTCOUNT, 32'(pulseCount), "OUTCOUNT");
        setReg(REG_OUTCOUNT, 32'h0000_5A5A);
        readCheck(REG_OUTCOUNT, 32'd0, "OUTCOUNT after clear");
        finishTest("output rate");
    endtask

    task automatic checkDisable();
        iqSample_t oldValue;
        iqSample_t newValue;
        testErrors = 0;
        oldValue.i = 18'sd500;
        oldValue.q = -18'sd500;
        newValue.i = -18'sd70000;
        newValue.q = 18'sd33333;
        setReg(REG_CTRL, 32'd0);
        clearCapture();
        feedSamples(oldValue, 20);
        idle(4);
        if (pulseCount != 0) begin
            $display("error: %0d outValid pulses while the filter was disabled", pulseCount);
            testErrors++;
        end
        runDc(newValue, 8, 4, 40, "re-enable");
        finishTest("disable");
    endtask

    task automatic checkRandomLevels();
        iqSample_t   value;
        logic [31:0] raw;
        int          shift;
        testErrors = 0;
        for (int trial = 0; trial < 3; trial++) begin
            raw     = randomBits(inputWidth);
            value.i = raw[inputWidth-1:0];
            raw     = randomBits(inputWidth);
            value.q = raw[inputWidth-1:0];
            shift   = 9 + int'(randomBits(4) % 12);
            runDc(value, shift, 8, 60, $sformatf("random level %0d", trial));
        end
        finishTest("random levels");
    endtask

    // **********************************************************************
    // main sequence
    // **********************************************************************

    initial begin
        lfsrState   = 16'd6173;
        testErrors  = 0;
        testsPassed = 0;
        testsFailed = 0;
        pulseCount  = 0;
        reset       = 1'b1;
        pSel        = 1'b0;
        pEnable     = 1'b0;
        pWrite      = 1'b0;
        pAddr       = '0;
        pWData      = '0;
        sampleValid = 1'b0;
        inSample    = '0;
        idle(10);
        reset = 1'b0;
        idle(2);

        checkRegisters();
        checkDcGain();
        checkOutputRate();
        checkDisable();
        checkRandomLevels();

        $display("tests passed: %0d, failed: %0d", testsPassed, testsFailed);
        if (testsFailed == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

// ==== verilog.f ====
hw/cicPkg.sv
hw/inputAligner.sv
hw/cicIntegrator.sv
hw/cicComb.sv
hw/cicDecimator.sv
hw/cicRegs.sv
hw/cicDecimatorTop.sv
tests/cicDecimatorTb.sv
